// ==== pu_types_pkg.sv ====
//--------------------------------------------------------------------------
// basic word and condition-register types of the processing unit
// the data path is fixed at 32 bits, so nothing here is meant to be resized
// cr_field follows the lt, gt, eq, ov order of one CR nibble
//--------------------------------------------------------------------------

package pu_types_pkg;

	// data path width
	localparam int dwidth = 32;

	// one general purpose register word, unsigned by default
	typedef logic [dwidth-1:0] word;

	// one condition-register field, msb first
	typedef struct packed {
		// result negative
		logic lt;
		// result positive
		logic gt;
		// result zero
		logic eq;
		// overflow of the operation
		logic ov;
	} cr_field;

endpackage

// ==== div_unit_pkg.sv ====
//--------------------------------------------------------------------------
// types and constants of the divide unit
// only divw and divwu are decoded, SO is not modelled
// div_latency is counted from the accepting edge to complete
//--------------------------------------------------------------------------

package div_unit_pkg;

	// primary opcode and 9-bit extended opcodes (XO form)
	localparam logic [5:0] op_primary = 6'd31;
	localparam logic [8:0] xo_divw = 9'd491;
	localparam logic [8:0] xo_divwu = 9'd459;

	// issue to complete, in clock cycles
	localparam int div_latency = 35;

	// one quotient bit per iteration
	localparam int core_cycles = pu_types_pkg::dwidth;
	localparam int core_cnt_width = $clog2(core_cycles + 1);

	// decoded divide operation, 67 bits
	typedef struct packed {
		logic uns;
		logic rc;
		logic oe;
		pu_types_pkg::word a;
		pu_types_pkg::word b;
	} div_op;

	// magnitude result plus what sign correction needs, 70 bits
	typedef struct packed {
		pu_types_pkg::word quotient;
		pu_types_pkg::word remainder;
		logic a_sgn;
		logic b_sgn;
		logic by_zero;
		logic illegal_signed;
		logic rc;
		logic oe;
	} div_raw;

	// final result handed to the consumer, 71 bits
	typedef struct packed {
		pu_types_pkg::word quotient;
		pu_types_pkg::word remainder;
		pu_types_pkg::cr_field crf;
		logic crf_we;
		logic ov_we;
		logic ov;
	} div_result_t;

endpackage

// ==== div_decode.sv ====
//--------------------------------------------------------------------------
// decoder for divw and divwu (XO form)
// op and valid are combinational from inst, a and b
// illegal is registered and only fires for an issue taken while ready
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module div_decode (
	input  logic              clk,
	input  logic              reset,
	input  logic              issue,
	input  logic              ready,
	input  logic [31:0]       inst,
	input  pu_types_pkg::word a,
	input  pu_types_pkg::word b,
	output div_unit_pkg::div_op op,
	output logic              valid,
	output logic              illegal
);
	import div_unit_pkg::*;

	logic [5:0] primary;
	logic [8:0] xo;
	logic is_divw;
	logic is_divwu;

	// field split, big-endian bit 0 is inst[31]
	assign primary = inst[31:26];
	assign xo = inst[9:1];

	assign is_divw = (primary == op_primary) && (xo == xo_divw);
	assign is_divwu = (primary == op_primary) && (xo == xo_divwu);
	assign valid = is_divw | is_divwu;

	always_comb begin
		op.uns = is_divwu;
		// Rc is the last bit of the word
		op.rc = inst[0];
		// OE sits just above the extended opcode
		op.oe = inst[10];
		op.a = a;
		op.b = b;
	end

	// one pulse per rejected issue
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			illegal <= 1'b0;
		end else begin
			illegal <= issue & ready & ~valid;
		end
	end

endmodule

// ==== div_seq_core.sv ====
//--------------------------------------------------------------------------
// unsigned radix-2 restoring divider, one quotient bit per clock
// operands are taken on start, done pulses core_cycles + 1 cycles later
// a start while busy restarts the division, the caller must avoid it
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module div_seq_core (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  pu_types_pkg::word dividend,
	input  pu_types_pkg::word divisor,
	output logic              done,
	output pu_types_pkg::word quotient,
	output pu_types_pkg::word remainder,
	output logic              by_zero
);
	import pu_types_pkg::*;
	import div_unit_pkg::*;

	logic [core_cnt_width-1:0] count;
	logic busy;

	// quo_q starts as the dividend and fills with quotient bits from the right
	word quo_q;
	word rem_q;
	word div_q;
	logic zero_q;

	// trial subtraction, one bit wider than a word
	logic [dwidth:0] shifted;
	logic [dwidth:0] diff;
	logic fits;

	always_comb begin
		// bring down the next dividend bit
		shifted = {rem_q, quo_q[dwidth-1]};
		diff = shifted - {1'b0, div_q};
		fits = shifted >= {1'b0, div_q};
	end

	//--------------------------------------------------------------------------
	// iteration control
	//--------------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				count <= core_cnt_width'(core_cycles);
			end else if (busy) begin
				count <= count - 1'b1;
				// last iteration happens on this edge
				if (count == core_cnt_width'(1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	//--------------------------------------------------------------------------
	// data path
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (start) begin
			quo_q <= dividend;
			rem_q <= '0;
			div_q <= divisor;
			// zero divisor noted once at load
			zero_q <= (divisor == '0);
		end else if (busy) begin
			if (fits) begin
				// remainder below divisor, so the low word is enough
				rem_q <= diff[dwidth-1:0];
				quo_q <= {quo_q[dwidth-2:0], 1'b1};
			end else begin
				// restore, keep the shifted partial remainder
				rem_q <= shifted[dwidth-1:0];
				quo_q <= {quo_q[dwidth-2:0], 1'b0};
			end
		end
	end

	// outputs valid while done is high and until the next start
	assign quotient = quo_q;
	assign remainder = rem_q;
	assign by_zero = zero_q;

endmodule

// ==== div_seq.sv ====
//--------------------------------------------------------------------------
// execute stage: control FSM, magnitude and sign capture, divider core
// ready is a level straight from the FSM, only idle accepts an issue
// raw_valid is high in the cycle the core reports done
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module div_seq (
	input  logic                clk,
	input  logic                reset,
	input  logic                issue,
	input  logic                valid,
	input  div_unit_pkg::div_op op,
	output logic                ready,
	output logic                raw_valid,
	output div_unit_pkg::div_raw raw
);
	import pu_types_pkg::*;

	// one-hot encoded control states
	typedef enum logic [3:0] {
		s_init     = 4'b0001,
		s_idle     = 4'b0010,
		s_on       = 4'b0100,
		s_complete = 4'b1000
	} state_t;

	state_t state;

	logic accept;
	logic a_neg;
	logic b_neg;

	// captured operation
	word a_mag;
	word b_mag;
	logic a_sgn;
	logic b_sgn;
	logic illegal_signed;
	logic rc_q;
	logic oe_q;

	// core handshake
	logic start;
	logic core_done;
	word core_quotient;
	word core_remainder;
	logic core_by_zero;

	assign ready = (state == s_idle);
	assign accept = ready & issue & valid;

	// negative only counts for the signed form
	assign a_neg = ~op.uns & op.a[dwidth-1];
	assign b_neg = ~op.uns & op.b[dwidth-1];

	//--------------------------------------------------------------------------
	// control FSM
	//--------------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= s_init;
		end else begin
			case (state)
				s_init: state <= s_idle;
				s_idle: begin
					if (accept)
						state <= s_on;
				end
				s_on: begin
					if (core_done)
						state <= s_complete;
				end
				s_complete: state <= s_idle;
				// lost one-hot code, start over
				default: state <= s_init;
			endcase
		end
	end

	// core start one cycle after the accepting edge
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			start <= 1'b0;
		end else begin
			start <= accept;
		end
	end

	// operand capture on acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			// 0x80000000 stays 0x80000000, which is the right magnitude
			a_mag <= a_neg ? -op.a : op.a;
			b_mag <= b_neg ? -op.b : op.b;
			a_sgn <= a_neg;
			b_sgn <= b_neg;
			illegal_signed <= ~op.uns && (op.a == {1'b1, {(dwidth-1){1'b0}}})
				&& (op.b == '1);
			rc_q <= op.rc;
			oe_q <= op.oe;
		end
	end

	div_seq_core core_inst (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.dividend  (a_mag),
		.divisor   (b_mag),
		.done      (core_done),
		.quotient  (core_quotient),
		.remainder (core_remainder),
		.by_zero   (core_by_zero)
	);

	//--------------------------------------------------------------------------
	// raw result towards the result stage
	//--------------------------------------------------------------------------
	assign raw_valid = (state == s_on) & core_done;

	always_comb begin
		raw.quotient = core_quotient;
		raw.remainder = core_remainder;
		raw.a_sgn = a_sgn;
		raw.b_sgn = b_sgn;
		raw.by_zero = core_by_zero;
		raw.illegal_signed = illegal_signed;
		raw.rc = rc_q;
		raw.oe = oe_q;
	end

endmodule

// ==== div_result.sv ====
//--------------------------------------------------------------------------
// result stage: sign fix, overflow, CR field and output registers
// quotient and remainder read as zero whenever ov is set
// result holds from one complete pulse to the next
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module div_result (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 raw_valid,
	input  div_unit_pkg::div_raw raw,
	output logic                 complete,
	output div_unit_pkg::div_result_t result
);
	import pu_types_pkg::*;
	import div_unit_pkg::*;

	logic ov;
	word q_signed;
	word r_signed;
	word q_final;
	word r_final;
	cr_field crf_next;
	div_result_t next;

	always_comb begin
		// by zero, or most negative over minus one
		ov = raw.by_zero | raw.illegal_signed;

		// quotient negative when exactly one operand is
		q_signed = (raw.a_sgn ^ raw.b_sgn) ? -raw.quotient : raw.quotient;
		// remainder follows the dividend
		r_signed = raw.a_sgn ? -raw.remainder : raw.remainder;

		q_final = ov ? '0 : q_signed;
		r_final = ov ? '0 : r_signed;

		// signed compare of the quotient against zero
		crf_next.lt = q_final[dwidth-1];
		crf_next.eq = (q_final == '0);
		crf_next.gt = ~q_final[dwidth-1] & (q_final != '0);
		crf_next.ov = ov;

		next.quotient = q_final;
		next.remainder = r_final;
		next.crf = crf_next;
		next.crf_we = raw.rc;
		next.ov_we = raw.oe;
		next.ov = ov;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			complete <= 1'b0;
			result <= '0;
		end else begin
			complete <= raw_valid;
			if (raw_valid)
				result <= next;
		end
	end

endmodule

// ==== div_unit.sv ====
//--------------------------------------------------------------------------
// divide unit top: decode, execute and result stages in a row
// no back-pressure, the consumer takes result on the complete pulse
// an issue while ready is low is dropped without any response
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module div_unit (
	input  logic              clk,
	input  logic              reset,
	input  logic              issue,
	input  logic [31:0]       inst,
	input  pu_types_pkg::word a,
	input  pu_types_pkg::word b,
	output logic              ready,
	output logic              illegal,
	output logic              complete,
	output div_unit_pkg::div_result_t result
);
	import div_unit_pkg::*;

	// decode to execute
	div_op op;
	logic valid;

	// execute to result
	div_raw raw;
	logic raw_valid;

	div_decode decode_inst (
		.clk     (clk),
		.reset   (reset),
		.issue   (issue),
		.ready   (ready),
		.inst    (inst),
		.a       (a),
		.b       (b),
		.op      (op),
		.valid   (valid),
		.illegal (illegal)
	);

	div_seq seq_inst (
		.clk       (clk),
		.reset     (reset),
		.issue     (issue),
		.valid     (valid),
		.op        (op),
		.ready     (ready),
		.raw_valid (raw_valid),
		.raw       (raw)
	);

	div_result result_inst (
		.clk       (clk),
		.reset     (reset),
		.raw_valid (raw_valid),
		.raw       (raw),
		.complete  (complete),
		.result    (result)
	);

endmodule

// ==== div_unit_tb.sv ====
//--------------------------------------------------------------------------
// testbench for the divide unit with one operation in flight at a time
// expected values come from a reference model of divw and divwu
// random operands come from a 32-bit Galois LFSR with seed 42, one step per bit
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module div_unit_tb;
	import pu_types_pkg::*;
	import div_unit_pkg::*;

	localparam int n_random = 40;
	localparam int n_corner = 14;
	localparam int n_bad = 4;
	// per operation budget plus room for reset and the end
	localparam int watchdog_ns = (n_random + n_corner + n_bad) * (div_latency + 4) * 100 + 5000;

	logic clk = 1'b0;
	logic reset;
	logic issue;
	logic [31:0] inst;
	word a;
	word b;
	logic ready;
	logic illegal;
	logic complete;
	div_result_t result;

	logic [31:0] lfsr_state;
	div_result_t last_result = '0;
	int n_div = 0;
	int n_illegal = 0;
	int complete_count = 0;
	int illegal_count = 0;
	logic inst_is_div;

	// directed corner operands
	// bit i of corner_uns selects divwu
	logic [31:0] corner_a [0:13] = '{32'h80000000, 32'h80000000, 32'h00003039, 32'h00003039,
		32'h00000000, 32'hffffffff, 32'h00000007, 32'hfffffff9, 32'hfffffff9,
		32'h00000000, 32'h80000000, 32'hffffffff, 32'h80000000, 32'h00000005};
	logic [31:0] corner_b [0:13] = '{32'hffffffff, 32'hffffffff, 32'h00000000, 32'h00000000,
		32'h00000000, 32'h00000001, 32'hfffffffe, 32'h00000002, 32'hfffffffe,
		32'h00000005, 32'h00000001, 32'hffffffff, 32'h00000002, 32'h00000007};
	logic [13:0] corner_uns = 14'b10100000001010;
	// non-divide words addi and add, one with the wrong primary, then divdu
	logic [31:0] bad_words [0:3] = '{32'h38600000, 32'h7c000214, 32'h78000000 | (491 << 1),
		32'h7c000000 | (457 << 1)};

	always #50 clk = ~clk;

	div_unit div_unit_inst (
		.clk      (clk),
		.reset    (reset),
		.issue    (issue),
		.inst     (inst),
		.a        (a),
		.b        (b),
		.ready    (ready),
		.illegal  (illegal),
		.complete (complete),
		.result   (result)
	);

	// own decode of the opcode fields
	assign inst_is_div = (inst[31:26] == 6'd31)
		&& ((inst[9:1] == 9'd491) || (inst[9:1] == 9'd459));

	//--------------------------------------------------------------------------
	// error reporting and stimulus helpers
	//--------------------------------------------------------------------------
	task automatic stop_failed();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic value_error(input string msg);
		$display("ERR %0t ns: %s", $time, msg);
		stop_failed();
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		stop_failed();
	endtask

	// galois form with taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < n; i++) begin
			w = {w[30:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return w;
	endfunction

	// XO form fields po, rt/ra/rb, OE, xo and Rc from the top
	function automatic logic [31:0] make_inst(input logic [5:0] po, input logic [8:0] xo,
			input logic oe, input logic rc, input logic [31:0] regs);
		return {po, regs[14:0], oe, xo, rc};
	endfunction

	// C-style truncating division
	// remainder takes the dividend sign
	task automatic reference_div(input logic uns, input logic [31:0] x, input logic [31:0] y,
			output logic [31:0] q, output logic [31:0] r, output logic ov);
		ov = (y == 32'd0) || (!uns && x == 32'h80000000 && y == 32'hffffffff);
		if (ov) begin
			q = '0;
			r = '0;
		end else if (uns) begin
			q = x / y;
			r = x % y;
		end else begin
			q = $signed(x) / $signed(y);
			r = $signed(x) % $signed(y);
		end
	endtask

	//--------------------------------------------------------------------------
	// one divide with an optional second issue while busy
	//--------------------------------------------------------------------------
	task automatic divide_and_check(input logic uns, input logic [31:0] op_a,
			input logic [31:0] op_b, input logic rc, input logic oe, input logic poke,
			input logic poke_bad);
		logic [31:0] inst_word;
		logic [31:0] exp_q;
		logic [31:0] exp_r;
		logic exp_ov;
		logic [31:0] back;
		int n;
		logic got;
		inst_word = make_inst(6'd31, uns ? 9'd459 : 9'd491, oe, rc, rand_bits(15));
		reference_div(uns, op_a, op_b, exp_q, exp_r, exp_ov);
		@(negedge clk);
		assert (ready && result == last_result) else value_error("not idle or result changed");
		@(posedge clk);
		issue <= 1'b1;
		inst <= inst_word;
		a <= op_a;
		b <= op_b;
		// accepting edge
		@(posedge clk);
		issue <= 1'b0;
		n = 0;
		got = 1'b0;
		while (!got) begin
			@(negedge clk);
			n = n + 1;
			if (complete)
				got = 1'b1;
			else if (n > div_latency + 10)
				abort_run("no complete pulse after an accepted divide");
			assert (!ready) else value_error("ready high while a divide is in flight");
			if (!got) begin
				@(posedge clk);
				// a second issue while busy must be dropped
				issue <= poke && (n == 10);
				if (poke && poke_bad && n == 10)
					inst <= 32'h7c000214;
			end
		end
		assert (n == div_latency)
			else value_error($sformatf("complete after %0d cycles, expected %0d", n, div_latency));
		assert (result.quotient == exp_q && result.remainder == exp_r)
			else value_error($sformatf("a=%h b=%h uns=%0d: q=%h r=%h, expected q=%h r=%h",
				op_a, op_b, uns, result.quotient, result.remainder, exp_q, exp_r));
		assert (result.ov == exp_ov && result.crf.ov == exp_ov)
			else value_error($sformatf("a=%h b=%h: ov=%0d, expected %0d", op_a, op_b,
				result.ov, exp_ov));
		assert (result.crf.lt == exp_q[31] && result.crf.eq == (exp_q == 32'd0)
				&& result.crf.gt == (!exp_q[31] && exp_q != 32'd0))
			else value_error($sformatf("crf=%b for quotient %h", result.crf, exp_q));
		assert (result.crf_we == rc && result.ov_we == oe)
			else value_error("crf_we or ov_we does not follow Rc or OE");
		// q * b + r gives a back modulo 2^32 for both forms
		back = result.quotient * op_b + result.remainder;
		assert (exp_ov || (back == op_a && (uns ? result.remainder < op_b
				: (result.remainder == 32'd0 || result.remainder[31] == op_a[31]))))
			else value_error($sformatf("a=%h b=%h: q*b+r=%h or remainder sign wrong", op_a,
				op_b, back));
		last_result = result;
		n_div = n_div + 1;
	endtask

	// a non-divide word gets an illegal pulse and nothing else
	task automatic send_bad_word(input logic [31:0] inst_word);
		@(negedge clk);
		assert (ready && result == last_result) else value_error("not idle before bad word");
		@(posedge clk);
		issue <= 1'b1;
		inst <= inst_word;
		@(posedge clk);
		issue <= 1'b0;
		@(negedge clk);
		assert (illegal && ready)
			else value_error($sformatf("no illegal pulse for %h", inst_word));
		for (int i = 0; i < div_latency + 2; i++) begin
			@(negedge clk);
			assert (!illegal && !complete && ready)
				else value_error($sformatf("unexpected response after bad word %h", inst_word));
		end
		n_illegal = n_illegal + 1;
	endtask

	//--------------------------------------------------------------------------
	// protocol checks
	//--------------------------------------------------------------------------
	complete_pulse: assert property (@(posedge clk) disable iff (reset) complete |=> !complete)
		else value_error("complete held for more than one cycle");
	busy_at_complete: assert property (@(posedge clk) disable iff (reset) complete |-> !ready)
		else value_error("ready high together with complete");
	illegal_idle: assert property (@(posedge clk) disable iff (reset)
			illegal |-> ready && !complete)
		else value_error("illegal pulse while busy or completing");
	ready_drop: assert property (@(posedge clk) disable iff (reset)
			issue && ready && inst_is_div |=> !ready)
		else value_error("ready still high after an accepted divide");
	ov_zeroes: assert property (@(posedge clk) disable iff (reset) complete && result.ov
			|-> result.quotient == '0 && result.remainder == '0)
		else value_error("quotient or remainder not zero under overflow");

	always @(negedge clk) begin
		if (complete)
			complete_count <= complete_count + 1;
		if (illegal)
			illegal_count <= illegal_count + 1;
	end

	initial begin
		#(watchdog_ns);
		abort_run("watchdog expired, the run did not finish in time");
	end

	//--------------------------------------------------------------------------
	// main sequence
	//--------------------------------------------------------------------------
	initial begin
		lfsr_state = 32'd42;
		reset = 1'b1;
		issue = 1'b0;
		inst = '0;
		a = '0;
		b = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		assert (!ready && !illegal && !complete && result == '0)
			else value_error("outputs not cleared during reset");
		@(posedge clk);
		reset <= 1'b0;
		// init state leaves on the next edge
		@(posedge clk);
		for (int i = 0; i < n_corner; i++)
			divide_and_check(corner_uns[i], corner_a[i], corner_b[i], i % 2 == 1,
				(i / 2) % 2 == 1, i == 6, 1'b0);
		for (int i = 0; i < n_bad; i++)
			send_bad_word(bad_words[i]);
		for (int i = 0; i < n_random; i++)
			divide_and_check(rand_bits(1) != 32'd0, rand_bits(32), rand_bits(32) >> rand_bits(5),
				rand_bits(1) != 32'd0, rand_bits(1) != 32'd0, i % 5 == 2, i % 10 == 2);
		repeat (3) @(negedge clk);
		if (complete_count == n_div && illegal_count == n_illegal) begin
			$display("Done: no errors");
			$finish;
		end else begin
			value_error($sformatf("%0d complete and %0d illegal pulses, expected %0d and %0d",
				complete_count, illegal_count, n_div, n_illegal));
		end
	end

endmodule

// ==== build.f ====
pu_types_pkg.sv
div_unit_pkg.sv
div_decode.sv
div_seq_core.sv
div_seq.sv
div_result.sv
div_unit.sv
div_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the divide unit testbench
# override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP ?= div_unit_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
